//--- files.f
source/isaPkg.sv
source/ctrlPkg.sv
source/ctrlIf.sv
source/fetchUnit.sv
source/registerFile.sv
source/alu.sv
source/controllerRv32i.sv
source/dataMemory.sv
source/executeUnit.sv
source/coreRv32i.sv
verif/core_props.sv
verif/tbCore.sv

//--- Bender.yml
package:
  name: core_rv32i

sources:
  - source/isaPkg.sv
  - source/ctrlPkg.sv
  - source/ctrlIf.sv
  - source/fetchUnit.sv
  - source/registerFile.sv
  - source/alu.sv
  - source/controllerRv32i.sv
  - source/dataMemory.sv
  - source/executeUnit.sv
  - source/coreRv32i.sv
  - target: test
    files:
      - verif/core_props.sv
      - verif/tbCore.sv

//--- verif/tbCore.sv
// Single-cycle core testbench
module tbCore;

    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;

    localparam DataWord RESET_PC   = 32'h0;
    localparam int      DMEM_WORDS = 256;
    localparam int      IMEM_WORDS = 512;
    localparam int      RAND_START = 128;             // Directed code lives below
    localparam int      RAND_COUNT = 360;
    localparam int      FINAL_IDX  = RAND_START + RAND_COUNT;
    localparam DataWord FINAL_PC   = RESET_PC + FINAL_IDX * 4;
    localparam int      TIMEOUT    = 2000;           // Cycles

    localparam Funct3 R_F3 [7] = '{F3_ADD, F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
    localparam Funct3 B_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    typedef struct packed {
        DataWord nextPc;
        logic    regWe;
        RegIdx   regIdx;
        DataWord regData;
        logic    memWe;
        DataWord memAddr;
        DataWord memData;
    } StepResult;

    logic    i_Clk = 1'b0;
    logic    i_rstN;
    InstWord i_Inst;
    DataWord o_Pc;
    logic    o_RegWrEnable;
    RegIdx   o_RegWrIdx;
    DataWord o_RegWrData;
    logic    o_MemWrEnable;
    DataWord o_MemAddr;
    DataWord o_MemWrData;

    InstWord   imem [IMEM_WORDS];
    DataWord   shadowReg [32];
    DataWord   shadowMem [DMEM_WORDS];
    DataWord   expPc;
    StepResult expected;
    logic      running = 1'b0;
    integer    seed;
    int        errors;
    int        retired;
    int        randRetired;
    int        progIdx;
    int        cycles;

    always #4 i_Clk = ~i_Clk;

    assign i_Inst = imem[o_Pc[10:2]];                // Instruction memory answers at once

    coreRv32i #(.RESET_PC(RESET_PC), .DMEM_WORDS(DMEM_WORDS)) dut (
        .i_Clk         (i_Clk),
        .i_rstN        (i_rstN),
        .i_Inst        (i_Inst),
        .o_Pc          (o_Pc),
        .o_RegWrEnable (o_RegWrEnable),
        .o_RegWrIdx    (o_RegWrIdx),
        .o_RegWrData   (o_RegWrData),
        .o_MemWrEnable (o_MemWrEnable),
        .o_MemAddr     (o_MemAddr),
        .o_MemWrData   (o_MemWrData)
    );

    function automatic InstWord rType(input Funct7 f7, input int rs2, input int rs1,
                                      input Funct3 f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
    endfunction

    function automatic InstWord iType(input int imm, input int rs1, input Funct3 f3,
                                      input int rd, input Opcode op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic InstWord sType(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic InstWord bType(input int imm, input int rs2, input int rs1,
                                      input Funct3 f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic InstWord jType(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    // ISA model of one instruction on the shadow state
    function automatic StepResult modelStep(input InstWord inst, input DataWord pc);
        StepResult r;
        DataWord   a;
        DataWord   b;
        DataWord   addr;
        DataWord   immI;
        DataWord   immS;
        DataWord   immB;
        DataWord   immJ;
        logic      take;
        a    = shadowReg[inst[19:15]];
        b    = shadowReg[inst[24:20]];
        immI = 32'($signed(inst[31:20]));
        immS = 32'($signed({inst[31:25], inst[11:7]}));
        immB = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
        immJ = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
        take = 1'b0;
        r        = '0;
        r.nextPc = pc + 32'd4;
        r.regIdx = inst[11:7];
        case (inst[6:0])
            OP_REG, OP_IMM: begin
                if (inst[6:0] == OP_IMM)
                    b = immI;
                r.regWe = 1'b1;
                case (inst[14:12])
                    F3_ADD  : r.regData = (inst[6:0] == OP_REG && inst[31:25] == 7'h20) ?
                                          a - b : a + b;
                    F3_SLT  : r.regData = {31'd0, $signed(a) < $signed(b)};
                    F3_SLTU : r.regData = {31'd0, a < b};
                    F3_XOR  : r.regData = a ^ b;
                    F3_OR   : r.regData = a | b;
                    F3_AND  : r.regData = a & b;
                    default : r.regWe = 1'b0;        // Shifts are not supported
                endcase
                if (inst[6:0] == OP_REG && inst[31:25] != 7'h00 &&
                    (inst[31:25] != 7'h20 || inst[14:12] != F3_ADD))
                    r.regWe = 1'b0;
            end
            OP_LOAD: begin
                addr      = a + immI;
                r.regWe   = (inst[14:12] == F3_WORD);
                r.regData = shadowMem[addr[9:2]];
            end
            OP_STORE: begin
                r.memWe   = (inst[14:12] == F3_WORD);
                r.memAddr = a + immS;
                r.memData = b;
            end
            OP_BRANCH: begin
                case (inst[14:12])
                    F3_BEQ  : take = (a == b);
                    F3_BNE  : take = (a != b);
                    F3_BLT  : take = ($signed(a) < $signed(b));
                    F3_BGE  : take = ($signed(a) >= $signed(b));
                    F3_BLTU : take = (a < b);
                    F3_BGEU : take = (a >= b);
                    default : take = 1'b0;
                endcase
                if (take)
                    r.nextPc = pc + immB;
            end
            OP_JAL: begin
                r.regWe   = 1'b1;
                r.regData = pc + 32'd4;
                r.nextPc  = pc + immJ;
            end
            OP_JALR: begin
                if (inst[14:12] == F3_JALR) begin
                    r.regWe   = 1'b1;
                    r.regData = pc + 32'd4;
                    r.nextPc  = (a + immI) & ~32'd1;
                end
            end
            default: ;                                // Unsupported retires as a no-op
        endcase
        return r;
    endfunction

    task automatic reportMismatch(input string name, input DataWord got, input DataWord want);
        errors++;
        $display("Error at %0t ns: %s expected %h, actual %h", $time, name, want, got);
    endtask

    task automatic emit(input InstWord inst);
        imem[progIdx] = inst;
        progIdx++;
    endtask

    // Branch eight bytes ahead over one counting instruction
    task automatic branchOverFiller(input Funct3 f3, input int rs1, input int rs2);
        emit(bType(8, rs2, rs1, f3));
        emit(iType(1, 20, F3_ADD, 20, OP_IMM));
    endtask

    task automatic loadProgram();
        int          i;
        int          kind;
        int          hop;
        int          rd;
        int          rs1;
        int          rs2;
        logic [31:0] rnd;
        for (i = 0; i < IMEM_WORDS; i++)
            imem[i] = iType(i, 0, F3_ADD, 0, OP_IMM);  // No-op tagged with its index
        progIdx = 0;
        for (i = 1; i < 32; i++)
            emit(iType($random(seed), 0, F3_ADD, i, OP_IMM));
        for (i = 0; i < 16; i++)
            emit(sType(i * 4, i + 1, 0));             // Data window used by random code
        emit(iType(-5, 0, F3_ADD, 1, OP_IMM));
        emit(iType(3, 0, F3_ADD, 2, OP_IMM));
        for (i = 0; i < 7; i++)
            emit(rType((i == 1) ? F7_ALT : F7_BASE, 2, 1, R_F3[i], 3 + i));
        emit(iType(100, 1, F3_ADD, 10, OP_IMM));
        emit(iType(12'h0f0, 1, F3_AND, 11, OP_IMM));
        emit(iType(12'h700, 2, F3_OR, 12, OP_IMM));
        emit(iType(12'h555, 1, F3_XOR, 13, OP_IMM));
        emit(iType(1, 1, F3_SLT, 14, OP_IMM));
        emit(iType(1, 1, F3_SLTU, 15, OP_IMM));       // -5 is huge unsigned
        emit(iType(-1, 2, F3_SLTU, 22, OP_IMM));
        emit(sType(64, 1, 0));
        emit(sType(68, 3, 0));
        emit(iType(64, 0, F3_WORD, 16, OP_LOAD));
        emit(iType(68, 0, F3_WORD, 21, OP_LOAD));
        for (i = 0; i < 6; i++) begin
            branchOverFiller(B_F3[i], 1, 2);
            branchOverFiller(B_F3[i], 2, 1);
        end
        branchOverFiller(F3_BEQ, 2, 2);
        branchOverFiller(F3_BNE, 1, 1);
        emit(jType(8, 17));
        emit(iType(1, 20, F3_ADD, 20, OP_IMM));
        emit(iType((progIdx + 2) * 4 + 1, 0, F3_JALR, 18, OP_JALR));  // Odd target
        emit(iType(1, 20, F3_ADD, 20, OP_IMM));
        emit(iType(5, 1, F3_ADD, 0, OP_IMM));         // Dropped write to x0
        emit(rType(F7_BASE, 2, 0, F3_ADD, 19));
        for (i = RAND_START; i < FINAL_IDX; i++) begin
            rnd  = $random(seed);
            kind = $unsigned($random(seed)) % 18;
            rd   = rnd[4:0];
            rs1  = rnd[9:5];
            rs2  = rnd[14:10];
            hop  = 1 + rnd[16:15];                    // Forward only
            if (i + hop > FINAL_IDX)
                hop = FINAL_IDX - i;
            if (kind < 7)
                imem[i] = rType((kind == 1) ? F7_ALT : F7_BASE, rs2, rs1, R_F3[kind], rd);
            else if (kind < 13)
                imem[i] = iType(rnd[31:20], rs1, R_F3[kind - 6], rd, OP_IMM);
            else if (kind == 13)
                imem[i] = iType(rnd[19:16] * 4, 0, F3_WORD, rd, OP_LOAD);
            else if (kind == 14)
                imem[i] = sType(rnd[19:16] * 4, rs2, 0);
            else if (kind == 15)
                imem[i] = bType(hop * 4, rs2, rs1, B_F3[rnd[31:29] % 6]);
            else if (kind == 16)
                imem[i] = jType(hop * 4, rd);
            else
                imem[i] = iType((i + hop) * 4 + rnd[20], 0, F3_JALR, rd, OP_JALR);
        end
        imem[FINAL_IDX] = jType(0, 0);                // Park here
    endtask

    // Mid-cycle compare against the model, then retire into the shadow state
    always @(negedge i_Clk) begin
        if (running) begin
            expected = modelStep(imem[expPc[10:2]], expPc);
            if (o_Pc !== expPc)
                reportMismatch("o_Pc", o_Pc, expPc);
            if (o_RegWrEnable !== expected.regWe)
                reportMismatch("o_RegWrEnable", 32'(o_RegWrEnable), 32'(expected.regWe));
            if (expected.regWe && o_RegWrIdx !== expected.regIdx)
                reportMismatch("o_RegWrIdx", 32'(o_RegWrIdx), 32'(expected.regIdx));
            if (expected.regWe && o_RegWrData !== expected.regData)
                reportMismatch("o_RegWrData", o_RegWrData, expected.regData);
            if (o_MemWrEnable !== expected.memWe)
                reportMismatch("o_MemWrEnable", 32'(o_MemWrEnable), 32'(expected.memWe));
            if (expected.memWe && o_MemAddr !== expected.memAddr)
                reportMismatch("o_MemAddr", o_MemAddr, expected.memAddr);
            if (expected.memWe && o_MemWrData !== expected.memData)
                reportMismatch("o_MemWrData", o_MemWrData, expected.memData);
            if (expected.regWe && expected.regIdx != 5'd0)
                shadowReg[expected.regIdx] = expected.regData;
            if (expected.memWe)
                shadowMem[expected.memAddr[9:2]] = expected.memData;
            if (expPc[10:2] >= RAND_START && expPc[10:2] < FINAL_IDX)
                randRetired++;
            retired++;
            expPc = expected.nextPc;
        end
    end

    initial begin
        int i;
        seed        = 50962;
        errors      = 0;
        retired     = 0;
        randRetired = 0;
        expPc       = RESET_PC;
        i_rstN     <= 1'b0;
        for (i = 0; i < 32; i++)
            shadowReg[i] = '0;
        loadProgram();
        repeat (3) begin
            @(posedge i_Clk);
            @(negedge i_Clk);
            if (o_Pc !== RESET_PC)
                reportMismatch("o_Pc", o_Pc, RESET_PC);
            if (o_RegWrEnable !== 1'b0)
                reportMismatch("o_RegWrEnable", 32'(o_RegWrEnable), 32'd0);
            if (o_MemWrEnable !== 1'b0)
                reportMismatch("o_MemWrEnable", 32'(o_MemWrEnable), 32'd0);
        end
        @(posedge i_Clk);
        i_rstN <= 1'b1;                               // Fourth reset edge
        running = 1'b1;
        cycles  = 0;
        while (o_Pc !== FINAL_PC && cycles < TIMEOUT) begin
            @(negedge i_Clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("Timeout: PC never reached the final address after %0d cycles", cycles);
        end
        repeat (2) @(posedge i_Clk);                  // Last compares are done by now
        if (randRetired < 200) begin
            errors++;
            $display("Only %0d random instructions retired, fewer than 200", randRetired);
        end
        $display("Run finished: %0d errors, %0d instructions checked, %0d random",
                 errors, retired, randRetired);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- verif/core_props.sv
// Core port assertions
module coreProps (
    input logic            i_Clk,
    input logic            i_rstN,
    input isaPkg::InstWord i_Inst,
    input isaPkg::DataWord i_Pc,
    input logic            i_RegWrEnable,
    input isaPkg::RegIdx   i_RegWrIdx,
    input isaPkg::DataWord i_RegWrData,
    input logic            i_MemWrEnable,
    input isaPkg::DataWord i_RsA,
    input isaPkg::DataWord i_RsB
);

    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;

    resetQuiet : assert property (@(posedge i_Clk)
        !i_rstN |-> (!i_RegWrEnable && !i_MemWrEnable))
        else $error("Write strobe active while in reset");

    // The register last written reads back its new value, and x0 stays zero
    writeReadBack : assert property (@(posedge i_Clk) disable iff (!i_rstN)
        $past(i_RegWrEnable) |->
            (i_Inst[19:15] != $past(i_RegWrIdx) ||
             i_RsA == (($past(i_RegWrIdx) == 5'd0) ? '0 : $past(i_RegWrData))) &&
            (i_Inst[24:20] != $past(i_RegWrIdx) ||
             i_RsB == (($past(i_RegWrIdx) == 5'd0) ? '0 : $past(i_RegWrData))))
        else $error("Register read after a write returned the wrong value");

    pcAligned : assert property (@(posedge i_Clk) disable iff (!i_rstN)
        i_Pc[1:0] == 2'b00)
        else $error("PC is not word aligned");

endmodule

bind coreRv32i coreProps uProps (
    .i_Clk         (i_Clk),
    .i_rstN        (i_rstN),
    .i_Inst        (i_Inst),
    .i_Pc          (o_Pc),
    .i_RegWrEnable (o_RegWrEnable),
    .i_RegWrIdx    (o_RegWrIdx),
    .i_RegWrData   (o_RegWrData),
    .i_MemWrEnable (o_MemWrEnable),
    .i_RsA         (rsA),
    .i_RsB         (rsB)
);

//--- source/coreRv32i.sv
// Single-cycle RV32I core
module coreRv32i #(
    parameter isaPkg::DataWord RESET_PC   = '0,
    parameter int              DMEM_WORDS = 256
) (
    input  logic            i_Clk,
    input  logic            i_rstN,
    input  isaPkg::InstWord i_Inst,      // From external instruction memory
    output isaPkg::DataWord o_Pc,
    output logic            o_RegWrEnable,
    output isaPkg::RegIdx   o_RegWrIdx,
    output isaPkg::DataWord o_RegWrData,
    output logic            o_MemWrEnable,
    output isaPkg::DataWord o_MemAddr,
    output isaPkg::DataWord o_MemWrData
);

    import isaPkg::*;
    import ctrlPkg::*;

    PcSel    pcNextSel;
    DataWord offset;
    DataWord indirectBase;
    DataWord rsA;
    DataWord rsB;

    fetchUnit #(.RESET_PC(RESET_PC)) uFetch (
        .i_Clk          (i_Clk),
        .i_rstN         (i_rstN),
        .i_PcNextSel    (pcNextSel),
        .i_Offset       (offset),
        .i_IndirectBase (indirectBase),
        .o_Pc           (o_Pc)
    );

    registerFile uRegFile (
        .i_Clk      (i_Clk),
        .i_RdIdxA   (i_Inst[19:15]),     // rs1
        .i_RdIdxB   (i_Inst[24:20]),     // rs2
        .i_WrEnable (o_RegWrEnable),
        .i_WrIdx    (o_RegWrIdx),
        .i_WrData   (o_RegWrData),
        .o_RdDataA  (rsA),
        .o_RdDataB  (rsB)
    );

    executeUnit #(.DMEM_WORDS(DMEM_WORDS)) uExecute (
        .i_Clk          (i_Clk),
        .i_rstN         (i_rstN),
        .i_Inst         (i_Inst),
        .i_Pc           (o_Pc),
        .i_RsA          (rsA),
        .i_RsB          (rsB),
        .o_PcNextSel    (pcNextSel),
        .o_Offset       (offset),
        .o_IndirectBase (indirectBase),
        .o_RegWrEnable  (o_RegWrEnable),
        .o_RegWrIdx     (o_RegWrIdx),
        .o_RegWrData    (o_RegWrData),
        .o_MemWrEnable  (o_MemWrEnable),
        .o_MemAddr      (o_MemAddr),
        .o_MemWrData    (o_MemWrData)
    );

endmodule

//--- source/executeUnit.sv
// Decode, execute and memory stage
module executeUnit #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            i_Clk,
    input  logic            i_rstN,
    input  isaPkg::InstWord i_Inst,
    input  isaPkg::DataWord i_Pc,
    input  isaPkg::DataWord i_RsA,
    input  isaPkg::DataWord i_RsB,
    output ctrlPkg::PcSel   o_PcNextSel,
    output isaPkg::DataWord o_Offset,
    output isaPkg::DataWord o_IndirectBase,
    output logic            o_RegWrEnable,
    output isaPkg::RegIdx   o_RegWrIdx,
    output isaPkg::DataWord o_RegWrData,
    output logic            o_MemWrEnable,
    output isaPkg::DataWord o_MemAddr,
    output isaPkg::DataWord o_MemWrData
);

    import isaPkg::*;
    import ctrlPkg::*;

    ctrlIf ctrl ();

    DataWord immI, immS, immB, immJ;
    DataWord operandB;
    DataWord aluResult;
    DataWord memRdData;
    DataWord pcPlus4;
    Opcode   opcode;
    logic    isEq;
    logic    isLt;

    assign opcode = i_Inst[6:0];

    assign immI = {{20{i_Inst[31]}}, i_Inst[31:20]};
    assign immS = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
    assign immB = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25], i_Inst[11:8], 1'b0};
    assign immJ = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20], i_Inst[30:21], 1'b0};

    assign operandB = !ctrl.operandBSel ? i_RsB :
                      (opcode == OP_STORE) ? immS : immI;  // Stores split their immediate

    controllerRv32i uController (.i_Inst(i_Inst), .i_IsEq(isEq), .i_IsLt(isLt), .ctrl(ctrl));

    alu uAlu (
        .i_Op       (ctrl.aluControl),
        .i_A        (i_RsA),
        .i_B        (operandB),
        .i_Unsigned (i_Inst[13]),        // BLTU and BGEU
        .o_Result   (aluResult),
        .o_IsEq     (isEq),
        .o_IsLt     (isLt)
    );

    dataMemory #(.DMEM_WORDS(DMEM_WORDS)) uDataMem (
        .i_Clk      (i_Clk),
        .i_WrEnable (o_MemWrEnable),
        .i_Addr     (aluResult),
        .i_WrData   (i_RsB),
        .o_RdData   (memRdData)
    );

    assign pcPlus4 = i_Pc + 32'd4;

    always_comb begin
        case (ctrl.dataToRegSel)
            WB_MEM  : o_RegWrData = memRdData;
            WB_PC4  : o_RegWrData = pcPlus4;    // Link for JAL and JALR
            default : o_RegWrData = aluResult;
        endcase
    end

    // Jumps and branches each carry their own immediate
    assign o_Offset = (opcode == OP_JAL)  ? immJ :
                      (opcode == OP_JALR) ? immI : immB;

    assign o_IndirectBase = i_RsA;
    assign o_PcNextSel    = ctrl.pcNextSel;
    assign o_RegWrIdx     = i_Inst[11:7];
    assign o_RegWrEnable  = ctrl.regWrEnable && i_rstN;  // No state change in reset
    assign o_MemWrEnable  = ctrl.memWrEnable && i_rstN;
    assign o_MemAddr      = aluResult;
    assign o_MemWrData    = i_RsB;

endmodule

//--- source/dataMemory.sv
// Word data RAM
module dataMemory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic            i_Clk,
    input  logic            i_WrEnable,
    input  isaPkg::DataWord i_Addr,      // Byte address
    input  isaPkg::DataWord i_WrData,
    output isaPkg::DataWord o_RdData
);

    import isaPkg::*;

    localparam int ADDR_BITS = $clog2(DMEM_WORDS);

    DataWord mem [DMEM_WORDS];

    logic [ADDR_BITS-1:0] wordIdx;

    // Low two bits select a byte and are ignored for word access
    assign wordIdx = i_Addr[ADDR_BITS+1:2];

    always_ff @(posedge i_Clk) begin
        if (i_WrEnable)
            mem[wordIdx] <= i_WrData;
    end

    assign o_RdData = mem[wordIdx];      // Asynchronous read

endmodule

//--- source/controllerRv32i.sv
// RV32I instruction decoder
module controllerRv32i (
    input  isaPkg::InstWord i_Inst,
    input  logic            i_IsEq,      // Operands equal
    input  logic            i_IsLt,      // Operand A below operand B
    ctrlIf.controller       ctrl
);

    import isaPkg::*;
    import ctrlPkg::*;

    //                                 BSel  WbSel   RegWr MemWr PcNext       AluOp
    localparam CtrlWord DP_NOP   = '{1'b0, WB_ALU, 1'b0, 1'b0, PC_PLUS4,    AluOp_Unknown};
    localparam CtrlWord DP_ADD   = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_ADD};
    localparam CtrlWord DP_SUB   = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_SUB};
    localparam CtrlWord DP_AND   = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_AND};
    localparam CtrlWord DP_OR    = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_OR};
    localparam CtrlWord DP_XOR   = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_XOR};
    localparam CtrlWord DP_SLT   = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_SLT};
    localparam CtrlWord DP_SLTU  = '{1'b0, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_SLTU};
    localparam CtrlWord DP_ADDI  = '{1'b1, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_ADD};
    localparam CtrlWord DP_ANDI  = '{1'b1, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_AND};
    localparam CtrlWord DP_ORI   = '{1'b1, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_OR};
    localparam CtrlWord DP_XORI  = '{1'b1, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_XOR};
    localparam CtrlWord DP_SLTI  = '{1'b1, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_SLT};
    localparam CtrlWord DP_SLTIU = '{1'b1, WB_ALU, 1'b1, 1'b0, PC_PLUS4,    AluOp_SLTU};
    localparam CtrlWord DP_LW    = '{1'b1, WB_MEM, 1'b1, 1'b0, PC_PLUS4,    AluOp_ADD};
    localparam CtrlWord DP_SW    = '{1'b1, WB_ALU, 1'b0, 1'b1, PC_PLUS4,    AluOp_ADD};
    localparam CtrlWord DP_BR    = '{1'b0, WB_ALU, 1'b0, 1'b0, PC_OFFSET,   AluOp_Unknown};
    localparam CtrlWord DP_JAL   = '{1'b0, WB_PC4, 1'b1, 1'b0, PC_OFFSET,   AluOp_Unknown};
    localparam CtrlWord DP_JALR  = '{1'b0, WB_PC4, 1'b1, 1'b0, PC_INDIRECT, AluOp_Unknown};

    Funct7   funct7;
    Funct3   funct3;
    Opcode   opcode;
    CtrlWord dp;
    logic    taken;                      // Branch condition met or jump

    assign funct7 = i_Inst[31:25];
    assign funct3 = i_Inst[14:12];
    assign opcode = i_Inst[6:0];

    always_comb begin
        unique casez ({funct3, opcode, i_IsEq, i_IsLt})
            {F3_BEQ,  OP_BRANCH, 2'b1?}  : taken = 1'b1;
            {F3_BNE,  OP_BRANCH, 2'b0?}  : taken = 1'b1;
            {F3_BLT,  OP_BRANCH, 2'b?1}  : taken = 1'b1;
            {F3_BGE,  OP_BRANCH, 2'b?0}  : taken = 1'b1;
            {F3_BLTU, OP_BRANCH, 2'b?1}  : taken = 1'b1;
            {F3_BGEU, OP_BRANCH, 2'b?0}  : taken = 1'b1;
            {3'b???,  OP_JAL,    2'b??}  : taken = 1'b1;
            {F3_JALR, OP_JALR,   2'b??}  : taken = 1'b1;
            default                      : taken = 1'b0;
        endcase
    end

    // Anything outside the table retires as a no-op
    always_comb begin
        unique casez ({funct7, funct3, opcode})
            {F7_BASE,    F3_ADD,  OP_REG}    : dp = DP_ADD;
            {F7_ALT,     F3_ADD,  OP_REG}    : dp = DP_SUB;
            {F7_BASE,    F3_AND,  OP_REG}    : dp = DP_AND;
            {F7_BASE,    F3_OR,   OP_REG}    : dp = DP_OR;
            {F7_BASE,    F3_XOR,  OP_REG}    : dp = DP_XOR;
            {F7_BASE,    F3_SLT,  OP_REG}    : dp = DP_SLT;
            {F7_BASE,    F3_SLTU, OP_REG}    : dp = DP_SLTU;
            {7'b???????, F3_ADD,  OP_IMM}    : dp = DP_ADDI;
            {7'b???????, F3_AND,  OP_IMM}    : dp = DP_ANDI;
            {7'b???????, F3_OR,   OP_IMM}    : dp = DP_ORI;
            {7'b???????, F3_XOR,  OP_IMM}    : dp = DP_XORI;
            {7'b???????, F3_SLT,  OP_IMM}    : dp = DP_SLTI;
            {7'b???????, F3_SLTU, OP_IMM}    : dp = DP_SLTIU;
            {7'b???????, F3_WORD, OP_LOAD}   : dp = DP_LW;
            {7'b???????, F3_WORD, OP_STORE}  : dp = DP_SW;
            {7'b???????, F3_BEQ,  OP_BRANCH} : dp = DP_BR;
            {7'b???????, F3_BNE,  OP_BRANCH} : dp = DP_BR;
            {7'b???????, F3_BLT,  OP_BRANCH} : dp = DP_BR;
            {7'b???????, F3_BGE,  OP_BRANCH} : dp = DP_BR;
            {7'b???????, F3_BLTU, OP_BRANCH} : dp = DP_BR;
            {7'b???????, F3_BGEU, OP_BRANCH} : dp = DP_BR;
            {7'b???????, 3'b???,  OP_JAL}    : dp = DP_JAL;
            {7'b???????, F3_JALR, OP_JALR}   : dp = DP_JALR;
            default                          : dp = DP_NOP;
        endcase
    end

    assign ctrl.operandBSel  = dp.operandBSel;
    assign ctrl.dataToRegSel = dp.dataToRegSel;
    assign ctrl.regWrEnable  = dp.regWrEnable;
    assign ctrl.memWrEnable  = dp.memWrEnable;
    assign ctrl.aluControl   = dp.aluControl;
    assign ctrl.pcNextSel    = taken ? dp.pcNextSel : PC_PLUS4;  // Untaken falls through

endmodule

//--- source/alu.sv
// Integer ALU with branch flags
module alu (
    input  isaPkg::AluOp    i_Op,
    input  isaPkg::DataWord i_A,
    input  isaPkg::DataWord i_B,
    input  logic            i_Unsigned,
    output isaPkg::DataWord o_Result,
    output logic            o_IsEq,
    output logic            o_IsLt
);

    import isaPkg::*;

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = $signed(i_A) < $signed(i_B);
    assign ltUnsigned = i_A < i_B;

    always_comb begin
        case (i_Op)
            AluOp_ADD  : o_Result = i_A + i_B;
            AluOp_SUB  : o_Result = i_A - i_B;
            AluOp_AND  : o_Result = i_A & i_B;
            AluOp_OR   : o_Result = i_A | i_B;
            AluOp_XOR  : o_Result = i_A ^ i_B;
            AluOp_SLT  : o_Result = {31'd0, ltSigned};
            AluOp_SLTU : o_Result = {31'd0, ltUnsigned};
            default    : o_Result = '0;         // Unknown op
        endcase
    end

    // Flags for the branch decision
    assign o_IsEq = (i_A == i_B);
    assign o_IsLt = i_Unsigned ? ltUnsigned : ltSigned;

endmodule

//--- source/registerFile.sv
// Integer register file
module registerFile (
    input  logic            i_Clk,
    input  isaPkg::RegIdx   i_RdIdxA,
    input  isaPkg::RegIdx   i_RdIdxB,
    input  logic            i_WrEnable,
    input  isaPkg::RegIdx   i_WrIdx,
    input  isaPkg::DataWord i_WrData,
    output isaPkg::DataWord o_RdDataA,
    output isaPkg::DataWord o_RdDataB
);

    import isaPkg::*;

    DataWord regs [1:31];                // x0 has no storage

    logic wrValid;

    assign wrValid = i_WrEnable && (i_WrIdx != '0);  // Writes to x0 are dropped

    always_ff @(posedge i_Clk) begin
        if (wrValid)
            regs[i_WrIdx] <= i_WrData;
    end

    // Reads see the value before this cycle's write
    assign o_RdDataA = (i_RdIdxA == '0) ? '0 : regs[i_RdIdxA];
    assign o_RdDataB = (i_RdIdxB == '0) ? '0 : regs[i_RdIdxB];

endmodule

//--- source/fetchUnit.sv
// Program counter
module fetchUnit #(
    parameter isaPkg::DataWord RESET_PC = '0
) (
    input  logic            i_Clk,
    input  logic            i_rstN,
    input  ctrlPkg::PcSel   i_PcNextSel,
    input  isaPkg::DataWord i_Offset,
    input  isaPkg::DataWord i_IndirectBase,
    output isaPkg::DataWord o_Pc
);

    import isaPkg::*;
    import ctrlPkg::*;

    DataWord pc;
    DataWord pcNext;
    DataWord indirectTarget;

    // JALR drops the lowest bit of the sum
    assign indirectTarget = (i_IndirectBase + i_Offset) & ~32'd1;

    always_comb begin
        unique case (i_PcNextSel)
            PC_OFFSET   : pcNext = pc + i_Offset;
            PC_INDIRECT : pcNext = indirectTarget;
            default     : pcNext = pc + 32'd4;
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN)
            pc <= RESET_PC;
        else
            pc <= pcNext;
    end

    assign o_Pc = pc;

endmodule

//--- source/ctrlIf.sv
// Decoded control bundle
interface ctrlIf;

    import isaPkg::*;
    import ctrlPkg::*;

    logic memWrEnable;
    logic regWrEnable;
    logic operandBSel;
    AluOp aluControl;
    WbSel dataToRegSel;
    PcSel pcNextSel;                     // Already resolved for branches

    modport controller (
        output memWrEnable, regWrEnable, operandBSel,
        output aluControl, dataToRegSel, pcNextSel
    );

    modport datapath (
        input memWrEnable, regWrEnable, operandBSel,
        input aluControl, dataToRegSel, pcNextSel
    );

endinterface

//--- source/ctrlPkg.sv
// Datapath control encodings
package ctrlPkg;

    typedef enum logic [1:0] {
        PC_PLUS4    = 2'b00,             // Sequential
        PC_OFFSET   = 2'b01,             // PC relative
        PC_INDIRECT = 2'b10              // Register relative
    } PcSel;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_MEM = 2'b01,
        WB_PC4 = 2'b10                   // Link address
    } WbSel;

    // One row of the decode table
    typedef struct packed {
        logic         operandBSel;       // Immediate as ALU operand B
        WbSel         dataToRegSel;
        logic         regWrEnable;
        logic         memWrEnable;
        PcSel         pcNextSel;         // Target used when taken
        isaPkg::AluOp aluControl;
    } CtrlWord;

endpackage

//--- source/isaPkg.sv
// RV32I encoding types
package isaPkg;

    typedef logic [31:0] InstWord;       // Raw instruction
    typedef logic [31:0] DataWord;       // Register or memory value
    typedef logic [4:0]  RegIdx;         // Register number
    typedef logic [6:0]  Opcode;
    typedef logic [2:0]  Funct3;
    typedef logic [6:0]  Funct7;

    localparam Opcode OP_REG    = 7'b0110011;
    localparam Opcode OP_IMM    = 7'b0010011;
    localparam Opcode OP_LOAD   = 7'b0000011;
    localparam Opcode OP_STORE  = 7'b0100011;
    localparam Opcode OP_BRANCH = 7'b1100011;
    localparam Opcode OP_JAL    = 7'b1101111;
    localparam Opcode OP_JALR   = 7'b1100111;

    localparam Funct3 F3_ADD  = 3'b000;  // ADD, SUB and ADDI
    localparam Funct3 F3_SLT  = 3'b010;
    localparam Funct3 F3_SLTU = 3'b011;
    localparam Funct3 F3_XOR  = 3'b100;
    localparam Funct3 F3_OR   = 3'b110;
    localparam Funct3 F3_AND  = 3'b111;
    localparam Funct3 F3_WORD = 3'b010;  // LW and SW
    localparam Funct3 F3_JALR = 3'b000;

    localparam Funct3 F3_BEQ  = 3'b000;
    localparam Funct3 F3_BNE  = 3'b001;
    localparam Funct3 F3_BLT  = 3'b100;
    localparam Funct3 F3_BGE  = 3'b101;
    localparam Funct3 F3_BLTU = 3'b110;
    localparam Funct3 F3_BGEU = 3'b111;

    localparam Funct7 F7_BASE = 7'b0000000;
    localparam Funct7 F7_ALT  = 7'b0100000;  // Selects SUB

    typedef enum logic [4:0] {
        AluOp_ADD,
        AluOp_SUB,
        AluOp_AND,
        AluOp_OR,
        AluOp_XOR,
        AluOp_SLT,
        AluOp_SLTU,
        AluOp_Unknown
    } AluOp;

endpackage
